/* hdl/pkt_macros.svh */
`ifndef PKT_MACROS_SVH
`define PKT_MACROS_SVH

// Stream word and side-band widths
`define DATA_WIDTH     64
`define TUSER_WIDTH    32

// Packet length sits in user[15:0]
`define LEN_WIDTH      16
`define ETH_TYPE_WIDTH 16

// Words treated as header
// Needs 3 or more so the IPv4 protocol byte falls inside the header
`define MAX_HDR_WORDS  3

// Statistics sizing
`define NUM_CLASSES    4
`define CNT_WIDTH      32

// Header field values used by the classifier
`define ETH_TYPE_IPV4  16'h0800
`define IP_PROTO_TCP   8'd6
`define IP_PROTO_UDP   8'd17

`endif

/* hdl/pkt_types_pkg.sv */
`include "pkt_macros.svh"

package pkt_types_pkg;

  // Stream data word, byte k in bits 8k+7:8k
  typedef logic [`DATA_WIDTH-1:0] pkt_data_t;

  // Side-band word
  // Low bits carry the packet length in bytes
  typedef logic [`TUSER_WIDTH-1:0] pkt_user_t;

  // Packet length in bytes
  typedef logic [`LEN_WIDTH-1:0] pkt_len_t;

  // Ethernet type field, frame bytes 12 and 13
  typedef logic [`ETH_TYPE_WIDTH-1:0] ethertype_t;

  // Monitor FSM states
  typedef enum logic [1:0] {
    IDLE     = 2'd0,  // Between packets, next word is word 0
    WAIT_HDR = 2'd1,  // Inside header, eoh not yet seen
    WAIT_EOP = 2'd2   // Header done, waiting for last
  } mon_state_t;

endpackage

/* hdl/stats_types_pkg.sv */
`include "pkt_macros.svh"

package stats_types_pkg;

  // Class index and one counter value
  typedef logic [$clog2(`NUM_CLASSES)-1:0] class_id_t;
  typedef logic [`CNT_WIDTH-1:0] count_t;

  // One counter per class
  typedef count_t count_arr_t [`NUM_CLASSES];

  // Class encodings
  localparam class_id_t CLASS_NON_IP   = class_id_t'(0);
  localparam class_id_t CLASS_TCP      = class_id_t'(1);
  localparam class_id_t CLASS_UDP      = class_id_t'(2);
  localparam class_id_t CLASS_IP_OTHER = class_id_t'(3);  // ICMP, truncated IPv4 etc

endpackage

/* hdl/pkt_stream_if.sv */
`timescale 1ns/1ps

// Annotated word stream between pipeline stages
// Valid only, a word moves in every cycle valid is high
interface pkt_stream_if import pkt_types_pkg::*; ();

  pkt_data_t data;
  pkt_user_t user;
  logic      valid;
  logic      last;   // Final word of packet
  logic      eoh;    // Final header word, one per packet

  modport src (
    output data, user, valid, last, eoh
  );

  modport dst (
    input data, user, valid, last, eoh
  );

endinterface

/* hdl/pkt_monitor.sv */
`timescale 1ns/1ps
`include "pkt_macros.svh"

module pkt_monitor import pkt_types_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  pkt_data_t s_data,
  input  pkt_user_t s_user,
  input  logic      s_valid,
  input  logic      s_last,
  pkt_stream_if.src mon,
  output logic      sample
);

  localparam int CNT_W = $clog2(`MAX_HDR_WORDS);
  localparam logic [CNT_W-1:0] HDR_LAST = CNT_W'(`MAX_HDR_WORDS - 1);  // Index of eoh word

  // First register stage
  pkt_data_t  in_data_d0;
  pkt_user_t  in_user_d0;
  logic       in_valid_d0;
  logic       in_last_d0;

  mon_state_t cur_state;
  mon_state_t nxt_state;
  logic [CNT_W-1:0] word_cnt;   // Index of the word now in stage 0
  logic [CNT_W-1:0] nxt_cnt;
  logic       eoh_c;            // Stage 0 word ends the header
  logic [1:0] sample_dly;       // Pulse chain towards sample

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      in_valid_d0 <= 1'b0;
      in_last_d0  <= 1'b0;
    end else begin
      in_valid_d0 <= s_valid;
      in_last_d0  <= s_last;
    end
  end

  always_ff @(posedge clk) begin
    in_data_d0 <= s_data;
    in_user_d0 <= s_user;
  end

  // Header tracking, gaps without valid leave state and count alone
  always_comb begin
    nxt_state = cur_state;
    nxt_cnt   = word_cnt;
    eoh_c     = 1'b0;
    case (cur_state)
      IDLE: begin
        if (in_valid_d0) begin
          if (in_last_d0) begin
            eoh_c = 1'b1;  // Single-word packet
          end else begin
            nxt_state = WAIT_HDR;
            nxt_cnt   = CNT_W'(1);
          end
        end
      end
      WAIT_HDR: begin
        if (in_valid_d0) begin
          if (in_last_d0 || word_cnt == HDR_LAST) begin
            eoh_c     = 1'b1;  // Header end or early end of packet
            nxt_state = in_last_d0 ? IDLE : WAIT_EOP;
          end else begin
            nxt_cnt = word_cnt + CNT_W'(1);
          end
        end
      end
      WAIT_EOP: begin
        if (in_valid_d0 && in_last_d0) nxt_state = IDLE;
      end
      default: nxt_state = IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cur_state  <= IDLE;
      word_cnt   <= '0;
      sample_dly <= 2'b00;
      sample     <= 1'b0;
      mon.valid  <= 1'b0;
      mon.last   <= 1'b0;
      mon.eoh    <= 1'b0;
    end else begin
      cur_state  <= nxt_state;
      word_cnt   <= nxt_cnt;
      sample_dly <= {sample_dly[0], eoh_c};
      sample     <= sample_dly[1];  // Two cycles behind mon.eoh
      mon.valid  <= in_valid_d0;
      mon.last   <= in_last_d0;
      mon.eoh    <= eoh_c;
    end
  end

  // Second stage payload
  always_ff @(posedge clk) begin
    mon.data <= in_data_d0;
    mon.user <= in_user_d0;
  end

endmodule

/* hdl/hdr_parser.sv */
`timescale 1ns/1ps
`include "pkt_macros.svh"

module hdr_parser import pkt_types_pkg::*, stats_types_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  pkt_stream_if.dst mon,
  output pkt_data_t m_data,
  output pkt_user_t m_user,
  output logic      m_valid,
  output logic      m_last,
  output logic      m_eoh,
  output class_id_t upd_class,
  output pkt_len_t  upd_len
);

  logic       first_word;  // Next valid word opens a packet
  logic [1:0] word_cnt;    // Index of next non-first word, saturates
  logic [1:0] word_idx;    // Index of the current word
  ethertype_t eth_field;   // Ethernet type position in word 1
  ethertype_t eth_type_q;
  ethertype_t eth_type;
  logic [7:0] ip_proto;
  logic       proto_ok;
  class_id_t  class_c;
  pkt_len_t   len_c;
  class_id_t  class_d1;
  pkt_len_t   len_d1;

  assign word_idx  = first_word ? 2'd0 : word_cnt;
  assign eth_field = {mon.data[39:32], mon.data[47:40]};  // Frame bytes 12, 13
  assign ip_proto  = mon.data[63:56];                     // Frame byte 23
  assign proto_ok  = (word_idx == 2'd2);                  // Protocol only in word 2
  assign len_c     = mon.user[`LEN_WIDTH-1:0];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      first_word <= 1'b1;
      word_cnt   <= 2'd0;
      eth_type_q <= '0;
    end else if (mon.valid) begin
      first_word <= mon.last;
      if (first_word) begin
        word_cnt   <= 2'd1;
        eth_type_q <= '0;
      end else begin
        if (word_cnt != 2'd3) word_cnt <= word_cnt + 2'd1;
        if (word_idx == 2'd1) eth_type_q <= eth_field;
      end
    end
  end

  // Bypass so a 2-word packet sees its own Ethernet type
  always_comb begin
    case (word_idx)
      2'd0:    eth_type = '0;
      2'd1:    eth_type = eth_field;
      default: eth_type = eth_type_q;
    endcase
  end

  always_comb begin
    if (eth_type != `ETH_TYPE_IPV4)
      class_c = CLASS_NON_IP;
    else if (proto_ok && ip_proto == `IP_PROTO_TCP)
      class_c = CLASS_TCP;
    else if (proto_ok && ip_proto == `IP_PROTO_UDP)
      class_c = CLASS_UDP;
    else
      class_c = CLASS_IP_OTHER;  // Other protocol or none seen
  end

  // Result held at eoh, second stage lines up with sample
  always_ff @(posedge clk) begin
    if (mon.eoh) begin
      class_d1 <= class_c;
      len_d1   <= len_c;
    end
    upd_class <= class_d1;
    upd_len   <= len_d1;
  end

  // Stream forwarding, one cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      m_valid <= 1'b0;
      m_last  <= 1'b0;
      m_eoh   <= 1'b0;
    end else begin
      m_valid <= mon.valid;
      m_last  <= mon.last;
      m_eoh   <= mon.eoh;
    end
  end

  always_ff @(posedge clk) begin
    m_data <= mon.data;
    m_user <= mon.user;
  end

endmodule

/* hdl/class_stats.sv */
`timescale 1ns/1ps
`include "pkt_macros.svh"

module class_stats import pkt_types_pkg::*, stats_types_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      sample,      // One pulse per packet
  input  class_id_t upd_class,
  input  pkt_len_t  upd_len,
  input  logic      stat_rd,
  input  class_id_t stat_class,
  output count_t    stat_pkts,
  output count_t    stat_bytes,
  output logic      stat_valid
);

  count_arr_t pkt_cnt;   // Packets per class
  count_arr_t byte_cnt;  // Bytes per class

  // Counters wrap at full width
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `NUM_CLASSES; i++) begin
        pkt_cnt[i]  <= '0;
        byte_cnt[i] <= '0;
      end
    end else if (sample) begin
      pkt_cnt[upd_class]  <= pkt_cnt[upd_class] + count_t'(1);
      byte_cnt[upd_class] <= byte_cnt[upd_class] + count_t'(upd_len);
    end
  end

  // Read strobe delayed one cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      stat_valid <= 1'b0;
    end else begin
      stat_valid <= stat_rd;
    end
  end

  // Registered read mux
  // Same-cycle update is seen on the next read
  always_ff @(posedge clk) begin
    if (stat_rd) begin
      stat_pkts  <= pkt_cnt[stat_class];
      stat_bytes <= byte_cnt[stat_class];
    end
  end

endmodule

/* hdl/monitor_top.sv */
`timescale 1ns/1ps

module monitor_top import pkt_types_pkg::*, stats_types_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  // Input stream
  input  pkt_data_t s_data,
  input  pkt_user_t s_user,
  input  logic      s_valid,
  input  logic      s_last,
  // Output stream 3 cycles behind input
  output pkt_data_t m_data,
  output pkt_user_t m_user,
  output logic      m_valid,
  output logic      m_last,
  output logic      m_eoh,
  // Counter read port
  input  logic      stat_rd,
  input  class_id_t stat_class,
  output count_t    stat_pkts,
  output count_t    stat_bytes,
  output logic      stat_valid
);

  logic      sample;     // Per-packet pulse from monitor
  class_id_t upd_class;
  pkt_len_t  upd_len;

  pkt_stream_if mon_bus ();

  pkt_monitor u_monitor (
    .clk     (clk),
    .reset   (reset),
    .s_data  (s_data),
    .s_user  (s_user),
    .s_valid (s_valid),
    .s_last  (s_last),
    .mon     (mon_bus.src),
    .sample  (sample)
  );

  hdr_parser u_parser (
    .clk       (clk),
    .reset     (reset),
    .mon       (mon_bus.dst),
    .m_data    (m_data),
    .m_user    (m_user),
    .m_valid   (m_valid),
    .m_last    (m_last),
    .m_eoh     (m_eoh),
    .upd_class (upd_class),
    .upd_len   (upd_len)
  );

  class_stats u_stats (
    .clk        (clk),
    .reset      (reset),
    .sample     (sample),
    .upd_class  (upd_class),
    .upd_len    (upd_len),
    .stat_rd    (stat_rd),
    .stat_class (stat_class),
    .stat_pkts  (stat_pkts),
    .stat_bytes (stat_bytes),
    .stat_valid (stat_valid)
  );

endmodule

/* tb/monitor_assertions.sv */
`timescale 1ns/1ps

// Protocol checks on the pkt_monitor output stream
module monitor_assertions (
  input logic clk,
  input logic reset,
  input logic valid,
  input logic last,
  input logic eoh,
  input logic sample
);

  int   fails_reset = 0;
  int   fails_valid = 0;
  int   fails_sample = 0;
  int   fails_hdr = 0;
  int   fail_cnt;    // Total, read by the testbench at the end
  logic hdr_done;    // eoh seen, last not yet

  assign fail_cnt = fails_reset + fails_valid + fails_sample + fails_hdr;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hdr_done <= 1'b0;
    end else if (valid && last) begin
      hdr_done <= 1'b0;  // Packet closed
    end else if (eoh) begin
      hdr_done <= 1'b1;
    end
  end

  a_reset_quiet: assert property (@(posedge clk) reset |-> !valid && !eoh && !sample)
    else begin
      $error("valid, eoh or sample high during reset");
      fails_reset++;
    end

  a_eoh_valid: assert property (@(posedge clk) disable iff (reset) eoh |-> valid)
    else begin
      $error("eoh without valid");
      fails_valid++;
    end

  // Sample is the eoh flag two cycles on, both ways
  a_sample_delay: assert property (@(posedge clk) disable iff (reset) sample == $past(eoh, 2))
    else begin
      $error("sample not exactly 2 cycles after eoh");
      fails_sample++;
    end

  a_one_eoh: assert property (@(posedge clk) disable iff (reset) hdr_done |-> !eoh)
    else begin
      $error("second eoh before last");
      fails_hdr++;
    end

endmodule

/* tb/monitor_tb.sv */
`timescale 1ns/1ps
`include "pkt_macros.svh"

module monitor_tb import pkt_types_pkg::*, stats_types_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 200;
  localparam int RD_TIMEOUT = 10;

  typedef struct packed {
    pkt_data_t data;
    pkt_user_t user;
    logic      last;
    logic      eoh;   // Expected end-of-header flag
    logic      gaps;  // Random idle cycles allowed before this word
  } word_t;

  logic      clk = 1'b0;
  logic      reset;
  pkt_data_t s_data;
  pkt_user_t s_user;
  logic      s_valid;
  logic      s_last;
  pkt_data_t m_data;
  pkt_user_t m_user;
  logic      m_valid;
  logic      m_last;
  logic      m_eoh;
  logic      stat_rd;
  class_id_t stat_class;
  count_t    stat_pkts;
  count_t    stat_bytes;
  logic      stat_valid;

  word_t  words[$];    // Stimulus from the data file
  word_t  exp_q[$];    // Driven, not yet seen at m_
  count_t exp_pkts[`NUM_CLASSES];
  count_t exp_bytes[`NUM_CLASSES];
  integer seed = 32'h2d75;
  int     err_cnt = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     eoh_cnt = 0;     // m_eoh words seen
  int     out_idx = 0;     // m_ words seen
  int     pkt_total = 0;

  monitor_top uut (
    .clk (clk), .reset (reset),
    .s_data (s_data), .s_user (s_user), .s_valid (s_valid), .s_last (s_last),
    .m_data (m_data), .m_user (m_user), .m_valid (m_valid), .m_last (m_last), .m_eoh (m_eoh),
    .stat_rd (stat_rd), .stat_class (stat_class),
    .stat_pkts (stat_pkts), .stat_bytes (stat_bytes), .stat_valid (stat_valid)
  );

  bind pkt_monitor monitor_assertions u_assert (
    .clk (clk), .reset (reset), .valid (mon.valid), .last (mon.last),
    .eoh (mon.eoh), .sample (sample)
  );

  always #20 clk = ~clk;  // 40 ns period

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d failed check(s)", name, err_cnt - errs_before);
    end
  endtask

  // P, W and E records, a # line is skipped
  task automatic load_tests();
    int        fd;
    int        code;
    byte       kind;
    string     rest;
    int        n_words;
    int        idx;
    int        gaps;
    int        last;
    int        cls;
    int        pkts;
    int        bytes;
    pkt_data_t d;
    pkt_user_t u;
    word_t     w;
    n_words = 0;
    idx = 0;
    gaps = 0;
    fd = $fopen("tb/monitor_tests.txt", "r");
    assert (fd != 0) else begin
      $display("could not open tb/monitor_tests.txt");
      err_cnt++;
    end
    if (fd == 0) return;
    while ($fscanf(fd, " %c", kind) == 1) begin
      case (kind)
        "P": begin
          code = $fscanf(fd, "%d %d", n_words, gaps);
          idx = 0;
          pkt_total++;
        end
        "W": begin
          code = $fscanf(fd, "%h %h %d", d, u, last);
          w.data = d;
          w.user = u;
          w.last = (last != 0);
          // Header ends at word MAX_HDR_WORDS-1, or at the last word of a shorter packet
          w.eoh  = (idx == `MAX_HDR_WORDS - 1) ||
                   (idx == n_words - 1 && n_words < `MAX_HDR_WORDS);
          w.gaps = (gaps != 0);
          words.push_back(w);
          idx++;
        end
        "E": begin
          code = $fscanf(fd, "%d %d %d", cls, pkts, bytes);
          exp_pkts[class_id_t'(cls)]  = count_t'(pkts);
          exp_bytes[class_id_t'(cls)] = count_t'(bytes);
        end
        default: code = $fgets(rest, fd);  // Comment
      endcase
    end
    $fclose(fd);
  endtask

  task automatic drive_stream();
    int idle;
    foreach (words[i]) begin
      idle = 0;
      if (words[i].gaps) idle = int'($unsigned($random(seed)) % 3);
      repeat (idle) begin
        @(posedge clk);
        s_valid <= 1'b0;
        s_last  <= 1'b0;
      end
      @(posedge clk);
      s_data  <= words[i].data;
      s_user  <= words[i].user;
      s_valid <= 1'b1;
      s_last  <= words[i].last;
      exp_q.push_back(words[i]);
    end
    @(posedge clk);
    s_valid <= 1'b0;
    s_last  <= 1'b0;
  endtask

  // One read strobe, stat_valid expected one cycle later
  task automatic read_class(input int cls, output count_t pkts, output count_t bytes);
    int cyc;
    @(posedge clk);
    stat_rd    <= 1'b1;
    stat_class <= class_id_t'(cls);
    @(posedge clk);
    stat_rd <= 1'b0;
    cyc = 0;
    do begin
      @(negedge clk);
      cyc++;
    end while (!stat_valid && cyc < RD_TIMEOUT);
    assert (stat_valid) else begin
      $display("stat_valid never rose after reading class %0d", cls);
      err_cnt++;
    end
    check_value($sformatf("class%0d_rd_latency", cls), 64'd1, 64'(cyc));
    pkts  = stat_pkts;
    bytes = stat_bytes;
  endtask

  // Output checker, samples on the falling edge
  initial begin
    word_t e;
    forever begin
      @(negedge clk);
      if (reset) continue;
      if (m_valid) begin
        if (m_eoh) eoh_cnt++;
        assert (exp_q.size() != 0) else begin
          $display("output word %0d came out with nothing driven", out_idx);
          err_cnt++;
        end
        if (exp_q.size() != 0) begin
          e = exp_q.pop_front();
          check_value($sformatf("word%0d_data", out_idx), 64'(e.data), 64'(m_data));
          check_value($sformatf("word%0d_user", out_idx), 64'(e.user), 64'(m_user));
          check_value($sformatf("word%0d_last", out_idx), 64'(e.last), 64'(m_last));
          check_value($sformatf("word%0d_eoh", out_idx), 64'(e.eoh), 64'(m_eoh));
        end
        out_idx++;
      end else begin
        assert (!m_eoh && !m_last) else begin
          $display("m_eoh or m_last high without m_valid");
          err_cnt++;
        end
      end
    end
  end

  initial begin
    int     errs;
    int     drain;
    int     assert_fails;
    count_t pkts;
    count_t bytes;
    reset      = 1'b1;
    s_data     = '0;
    s_user     = '0;
    s_valid    = 1'b0;
    s_last     = 1'b0;
    stat_rd    = 1'b0;
    stat_class = '0;
    foreach (exp_pkts[c]) begin
      exp_pkts[c]  = '0;
      exp_bytes[c] = '0;
    end
    load_tests();
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    // Counters start at zero
    for (int c = 0; c < `NUM_CLASSES; c++) begin
      errs = err_cnt;
      read_class(c, pkts, bytes);
      check_value($sformatf("reset_class%0d_pkts", c), 64'd0, 64'(pkts));
      check_value($sformatf("reset_class%0d_bytes", c), 64'd0, 64'(bytes));
      end_test($sformatf("reset_class%0d", c), errs);
    end

    errs = err_cnt;
    drive_stream();
    drain = 0;
    while (exp_q.size() != 0 && drain < TIMEOUT_CYCLES) begin
      @(negedge clk);
      drain++;
    end
    assert (exp_q.size() == 0) else begin
      $display("timed out with %0d words still in the pipeline", exp_q.size());
      err_cnt++;
    end
    end_test("stream", errs);

    errs = err_cnt;
    check_value("eoh_count", 64'(pkt_total), 64'(eoh_cnt));
    end_test("eoh_count", errs);

    repeat (4) @(posedge clk);  // Last sample 2 cycles after final eoh, count a cycle later
    for (int c = 0; c < `NUM_CLASSES; c++) begin
      errs = err_cnt;
      read_class(c, pkts, bytes);
      check_value($sformatf("class%0d_pkts", c), 64'(exp_pkts[class_id_t'(c)]), 64'(pkts));
      check_value($sformatf("class%0d_bytes", c), 64'(exp_bytes[class_id_t'(c)]), 64'(bytes));
      end_test($sformatf("class%0d_totals", c), errs);
    end

    errs = err_cnt;
    assert_fails = uut.u_monitor.u_assert.fail_cnt;
    assert (assert_fails == 0) else begin
      $display("%0d protocol assertion failures on the monitor stream", assert_fails);
      err_cnt++;
    end
    end_test("protocol", errs);

    $display("%0d tests, %0d passed, %0d failed, %0d failed checks",
             tests_run, tests_run - tests_failed, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* tb/monitor_tests.txt */
# P words gaps (1 allows random idle cycles) / W data user last (hex, hex, 0 or 1)
# E class packets bytes (decimal), user[15:0] of each word is the packet length
P 3 1
W 0011223344556677 a100003c 0
W 1111000801020304 a101003c 0
W 0600000040000045 a102003c 1
P 4 1
W 0123456789abcdef b2000048 0
W 2222000805060708 b2010048 0
W 1100000080000045 b2020048 0
W f0e0d0c0b0a09080 b2030048 1
P 3 1
W 1020304050607080 c300002a 0
W 3333000809090909 c301002a 0
W 0100000000000045 c302002a 1
P 3 1
W ffffffffffffaaaa d400003c 0
W 444406080a0b0c0d d401003c 0
W 0600000000000001 d402003c 1
P 2 0
W 5555555555555555 e5000014 0
W 0666000806060606 e5010014 1
P 1 0
W 0101010101010101 17000040 1
P 1 0
W 0202020202020202 18000041 1
P 1 0
W 0303030303030303 19000042 1
E 0 4 255
E 1 1 60
E 2 1 72
E 3 2 62

/* vlog.f */
+incdir+hdl
hdl/pkt_types_pkg.sv
hdl/stats_types_pkg.sv
hdl/pkt_stream_if.sv
hdl/pkt_monitor.sv
hdl/hdr_parser.sv
hdl/class_stats.sv
hdl/monitor_top.sv
tb/monitor_assertions.sv
tb/monitor_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and pass only if the testbench reports success
rm -rf obj_dir &&
verilator --binary --timing --assert -f vlog.f --top-module monitor_tb -o monitor_sim &&
./obj_dir/monitor_sim +verilator+error+limit+1000 | tee /dev/stderr |
  grep -x "Result: PASSED" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
